//--- cache.f
+incdir+.
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
cache_top.sv
cache_tb_mem.sv
cache_properties.sv
cache_tb.sv

//--- Bender.yml
package:
  name: cache

export_include_dirs:
  - .

sources:
  - cache_pkg.sv
  - cache_tag_store.sv
  - cache_data_store.sv
  - cache_ctrl.sv
  - cache_top.sv
  - target: test
    files:
      - cache_tb_mem.sv
      - cache_properties.sv
      - cache_tb.sv

//--- cache_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module cache_tb;

  localparam logic [31:0] seed = 32'h30a5;
  localparam int reset_cycles = 10;
  localparam int seq_ops      = 16;
  localparam int be_ops       = 16;
  localparam int evict_lines  = 5;
  localparam int hit_pairs    = 8;
  localparam int rand_ops     = 400;
  localparam int mem_words    = 1024;
  localparam int op_total = seq_ops + 2 * be_ops + 2 * evict_lines + 2 * hit_pairs + rand_ops;
  localparam int timeout_cycles = op_total * 40 + reset_cycles;

  logic                clock;
  logic                rst_n;
  logic                mem_stall;
  cache_pkg::cpu_req_t cpu_req;
  cache_pkg::word_t    cpu_rd_data;
  logic                cpu_waitrequest;
  cache_pkg::mem_req_t mem_req;
  cache_pkg::word_t    mem_rd_data;
  logic                mem_rd_valid;
  logic                mem_waitrequest;

  logic [31:0]      rng;
  logic [31:0]      stall_rng;
  int               cycles;
  cache_pkg::word_t shadow [mem_words];
  logic             touched [mem_words];

  // reference LRU model of the tag store.
  cache_pkg::tag_t m_tag   [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::way_t m_age   [`CACHE_SETS][`CACHE_WAYS];
  logic            m_valid [`CACHE_SETS][`CACHE_WAYS];
  logic            m_dirty [`CACHE_SETS][`CACHE_WAYS];
  logic            wb_expected;
  logic            fill_expected;
  logic [31:0]     exp_wb_line;
  logic [31:0]     exp_fill_line;
  int              wb_beat;

  cache_top i_dut (
    .clock           (clock),
    .rst_n           (rst_n),
    .cpu_req         (cpu_req),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .mem_req         (mem_req),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest)
  );

  cache_tb_mem i_mem (
    .clock       (clock),
    .rst_n       (rst_n),
    .stall       (mem_stall),
    .mem_req     (mem_req),
    .rd_data     (mem_rd_data),
    .rd_valid    (mem_rd_valid),
    .waitrequest (mem_waitrequest)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
                                                   input cache_pkg::word_t new_w,
                                                   input cache_pkg::be_t be);
    cache_pkg::word_t r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_mem_req(input string name, input cache_pkg::mem_req_t got,
                               input cache_pkg::mem_req_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
  endtask

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift(rng);
    r   = rng;
  endtask

  // predicts hit, victim and write-back, then applies the access to the model.
  task automatic model_access(input logic [31:0] addr, input logic is_wr, output logic hit);
    int              set;
    int              way;
    cache_pkg::way_t a;
    set = addr[7:4];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == addr[31:8]) begin
        hit = 1'b1;
        way = w;
      end
    end
    wb_expected   = 1'b0;
    fill_expected = !hit;
    exp_fill_line = {addr[31:4], 4'h0};
    wb_beat       = 0;
    if (!hit) begin
      for (int w = 0; w < `CACHE_WAYS; w++) if (m_age[set][w] == '1) way = w;
      for (int w = `CACHE_WAYS - 1; w >= 0; w--) if (!m_valid[set][w]) way = w;
      wb_expected    = m_valid[set][way] && m_dirty[set][way];
      exp_wb_line    = {m_tag[set][way], addr[7:4], 4'h0};
      m_tag[set][way]   = addr[31:8];
      m_valid[set][way] = 1'b1;
      m_dirty[set][way] = 1'b0;
    end
    a = m_age[set][way];
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (w == way) m_age[set][w] = '0;
      else if (m_age[set][w] < a) m_age[set][w] = m_age[set][w] + 1'b1;
    end
    if (is_wr) m_dirty[set][way] = 1'b1;
  endtask

  function automatic logic resident_dirty(input logic [31:0] addr);
    logic r;
    r = 1'b0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (m_valid[addr[7:4]][w] && m_tag[addr[7:4]][w] == addr[31:8]) r = m_dirty[addr[7:4]][w];
    end
    return r;
  endfunction

  // called and returns on a falling edge; lat counts cycles to completion.
  task automatic access(input logic [31:0] addr, input logic is_wr, input cache_pkg::be_t be,
                        input cache_pkg::word_t wdata, output int lat);
    logic             hit;
    cache_pkg::word_t exp;
    model_access(addr, is_wr, hit);
    exp = shadow[addr[11:2]];
    cpu_req.address = addr;
    cpu_req.rd      = !is_wr;
    cpu_req.wr      = is_wr;
    cpu_req.be      = be;
    cpu_req.wdata   = wdata;
    lat = 0;
    do begin
      @(negedge clock);
      lat++;
    end while (cpu_waitrequest);
    if (is_wr) begin
      shadow[addr[11:2]]  = merge_bytes(exp, wdata, be);
      touched[addr[11:2]] = 1'b1;
    end else begin
      check_word("cpu_rd_data", cpu_rd_data, exp);
    end
    if (hit) check_latency("hit latency", lat, 2);
    @(posedge clock);
    @(negedge clock);
    cpu_req.rd = 1'b0;
    cpu_req.wr = 1'b0;
  endtask

  // ------------------------------------------------------------
  // memory port monitor, stalls and timeout
  // ------------------------------------------------------------

  always @(posedge clock) begin
    cache_pkg::mem_req_t exp;
    if (rst_n && mem_req.wr && !mem_waitrequest) begin
      exp           = mem_req;
      exp.address   = exp_wb_line;
      exp.burst_len = 2'd3;
      exp.rd        = 1'b0;
      exp.wr        = wb_expected;
      exp.wdata     = shadow[10'(exp_wb_line[11:2] + wb_beat)];
      check_mem_req("mem_req write beat", mem_req, exp);
      wb_beat = wb_beat + 1;
    end
    if (rst_n && mem_req.rd && !mem_waitrequest) begin
      exp           = mem_req;
      exp.address   = exp_fill_line;
      exp.burst_len = 2'd3;
      exp.rd        = fill_expected;
      exp.wr        = 1'b0;
      check_mem_req("mem_req read", mem_req, exp);
    end
  end

  always @(negedge clock) begin
    stall_rng = xorshift(stall_rng);
    mem_stall = stall_rng[1:0] == 2'b00; // about one cycle in four.
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > timeout_cycles) abort_run("timeout: the tests did not finish in time");
    if (i_dut.i_props.fail_count != 0) abort_run("a handshake assertion failed");
  end

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] addr;
    int          lat;
    rng       = seed;
    stall_rng = seed ^ 32'h5a5a_0001;
    cycles    = 0;
    rst_n     = 1'b0;
    cpu_req   = '0;
    mem_stall = 1'b1;
    wb_beat   = 0;
    for (int i = 0; i < mem_words; i++) begin
      shadow[i]  = i;
      touched[i] = 1'b0;
    end
    for (int s = 0; s < `CACHE_SETS; s++) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_age[s][w]   = cache_pkg::way_t'(w);
      end
    end
    repeat (reset_cycles) @(negedge clock);
    rst_n = 1'b1;

    for (int i = 0; i < seq_ops; i++) access(i * 4, 1'b0, 4'hf, '0, lat); // cold reads.

    for (int i = 0; i < be_ops; i++) begin
      next_rand(r);
      next_rand(d);
      addr = {23'd0, r[6:0], 2'b00};
      access(addr, 1'b1, r[11:8], d, lat);
      access(addr, 1'b0, 4'hf, '0, lat);
    end

    // five lines of set 5 overflow its four ways.
    for (int k = 0; k < evict_lines; k++) begin
      next_rand(d);
      access((k * 16 + 5) * 16 + 4, 1'b1, 4'hf, d, lat);
    end
    for (int k = 0; k < evict_lines; k++) access((k * 16 + 5) * 16 + 4, 1'b0, 4'hf, '0, lat);

    for (int i = 0; i < hit_pairs; i++) begin
      next_rand(r);
      addr = {23'd0, r[6:0], 2'b00};
      access(addr, r[8], 4'hf, r, lat);
      access(addr ^ 32'h4, 1'b0, 4'hf, '0, lat);
      check_latency("same line read latency", lat, 2);
    end

    for (int i = 0; i < rand_ops; i++) begin
      next_rand(r);
      next_rand(d);
      access({23'd0, r[6:0], 2'b00}, r[16], r[11:8], d, lat);
    end

    for (int i = 0; i < mem_words; i++) begin
      if (touched[i] && i_mem.mem_q[i] !== shadow[i] && !resident_dirty(i * 4)) begin
        abort_run($sformatf("memory word at %h is stale and its line is not held dirty", i * 4));
      end
    end

    if (i_dut.i_props.fail_count != 0) begin
      abort_run("a handshake assertion failed");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- cache_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cache_properties (
  input wire logic                clock,
  input wire logic                rst_n,
  input wire cache_pkg::cpu_req_t cpu_req,
  input wire logic                cpu_waitrequest,
  input wire cache_pkg::mem_req_t mem_req,
  input wire logic                mem_waitrequest
);

  int unsigned fail_count = 0;

  // ------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------

  cpu_hold: assert property (@(posedge clock) disable iff (!rst_n)
    (cpu_req.rd || cpu_req.wr) && cpu_waitrequest |=> $stable(cpu_req))
    else begin
      $error("cpu request changed while waitrequest was high");
      fail_count++;
    end

  mem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    (mem_req.rd || mem_req.wr) && mem_waitrequest |=> $stable(mem_req))
    else begin
      $error("memory request changed while waitrequest was high");
      fail_count++;
    end

  cpu_one_op: assert property (@(posedge clock) disable iff (!rst_n)
    !(cpu_req.rd && cpu_req.wr))
    else begin
      $error("cpu rd and wr both high");
      fail_count++;
    end

  mem_one_op: assert property (@(posedge clock) disable iff (!rst_n)
    !(mem_req.rd && mem_req.wr))
    else begin
      $error("memory rd and wr both high");
      fail_count++;
    end

  mem_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    (mem_req.rd || mem_req.wr) |-> mem_req.address[3:0] == 4'h0)
    else begin
      $error("memory address is not line aligned");
      fail_count++;
    end

  // state is unknown before the first edge, so this looks one cycle on.
  mem_quiet_in_reset: assert property (@(posedge clock)
    !rst_n |=> !mem_req.rd && !mem_req.wr)
    else begin
      $error("memory request during reset");
      fail_count++;
    end

endmodule

bind cache_top cache_properties i_props (
  .clock           (clock),
  .rst_n           (rst_n),
  .cpu_req         (cpu_req),
  .cpu_waitrequest (cpu_waitrequest),
  .mem_req         (mem_req),
  .mem_waitrequest (mem_waitrequest)
);

`default_nettype wire

//--- cache_tb_mem.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module cache_tb_mem (
  input  wire logic                clock,
  input  wire logic                rst_n,
  input  wire logic                stall,
  input  wire cache_pkg::mem_req_t mem_req,
  output cache_pkg::word_t         rd_data,
  output logic                     rd_valid,
  output logic                     waitrequest
);

  localparam int words = 1024;

  cache_pkg::word_t mem_q [words];
  int               rd_left;
  int               wr_beat;
  logic [9:0]       rd_ptr;
  logic             gap_q;

  initial begin
    for (int i = 0; i < words; i++) mem_q[i] = i; // word i holds i.
    rd_data  = '0;
    rd_valid = 1'b0;
    rd_left  = 0;
    wr_beat  = 0;
    rd_ptr   = '0;
    gap_q    = 1'b0;
  end

  assign waitrequest = stall;

  // commands and write beats are taken at the rising edge.
  always @(posedge clock) begin
    gap_q = stall; // read beats pause when the bus stalls.
    if (!rst_n) begin
      rd_left = 0;
      wr_beat = 0;
    end else begin
      if (mem_req.rd && !waitrequest) begin
        rd_ptr  = mem_req.address[11:2];
        rd_left = `CACHE_LINE_WORDS;
      end
      if (mem_req.wr && !waitrequest) begin
        mem_q[10'(mem_req.address[11:2] + wr_beat)] = mem_req.wdata;
        wr_beat = (wr_beat + 1) % `CACHE_LINE_WORDS;
      end
    end
  end

  always @(negedge clock) begin
    rd_valid <= 1'b0;
    if (rd_left > 0 && !gap_q) begin
      rd_data  <= mem_q[rd_ptr];
      rd_valid <= 1'b1;
      rd_ptr   = rd_ptr + 1'b1;
      rd_left  = rd_left - 1;
    end
  end

endmodule

`default_nettype wire

//--- cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module cache_top (
  input  wire logic                clock,
  input  wire logic                rst_n,
  input  wire cache_pkg::cpu_req_t cpu_req,
  output cache_pkg::word_t         cpu_rd_data,
  output logic                     cpu_waitrequest,
  output cache_pkg::mem_req_t      mem_req,
  input  wire cache_pkg::word_t    mem_rd_data,
  input  wire logic                mem_rd_valid,
  input  wire logic                mem_waitrequest
);

  cache_pkg::index_t   index;
  cache_pkg::tag_t     lookup_tag;
  logic                hit;
  cache_pkg::way_t     hit_way;
  cache_pkg::way_t     victim_way;
  cache_pkg::tag_t     victim_tag;
  logic                victim_dirty;
  logic                upd_en;
  cache_pkg::way_t     upd_way;
  logic                fill_en;
  logic                set_dirty;
  cache_pkg::ds_addr_t rd_addr;
  cache_pkg::word_t    rd_data;
  logic                wr_en;
  cache_pkg::ds_addr_t wr_addr;
  cache_pkg::be_t      wr_be;
  cache_pkg::word_t    wr_data;

  cache_ctrl i_ctrl (
    .clock           (clock),
    .rst_n           (rst_n),
    .cpu_req         (cpu_req),
    .cpu_rd_data     (cpu_rd_data),
    .cpu_waitrequest (cpu_waitrequest),
    .mem_req         (mem_req),
    .mem_rd_data     (mem_rd_data),
    .mem_rd_valid    (mem_rd_valid),
    .mem_waitrequest (mem_waitrequest),
    .index           (index),
    .lookup_tag      (lookup_tag),
    .hit             (hit),
    .hit_way         (hit_way),
    .victim_way      (victim_way),
    .victim_tag      (victim_tag),
    .victim_dirty    (victim_dirty),
    .upd_en          (upd_en),
    .upd_way         (upd_way),
    .fill_en         (fill_en),
    .set_dirty       (set_dirty),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_be           (wr_be),
    .wr_data         (wr_data)
  );

  cache_tag_store i_tag_store (
    .clock        (clock),
    .rst_n        (rst_n),
    .index        (index),
    .lookup_tag   (lookup_tag),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_tag   (victim_tag),
    .victim_dirty (victim_dirty),
    .upd_en       (upd_en),
    .upd_way      (upd_way),
    .fill_en      (fill_en),
    .set_dirty    (set_dirty)
  );

  cache_data_store i_data_store (
    .clock   (clock),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_be   (wr_be),
    .wr_data (wr_data)
  );

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module cache_ctrl (
  input  wire logic                clock,
  input  wire logic                rst_n,
  input  wire cache_pkg::cpu_req_t cpu_req,
  output cache_pkg::word_t         cpu_rd_data,
  output logic                     cpu_waitrequest,
  output cache_pkg::mem_req_t      mem_req,
  input  wire cache_pkg::word_t    mem_rd_data,
  input  wire logic                mem_rd_valid,
  input  wire logic                mem_waitrequest,
  output cache_pkg::index_t        index,
  output cache_pkg::tag_t          lookup_tag,
  input  wire logic                hit,
  input  wire cache_pkg::way_t     hit_way,
  input  wire cache_pkg::way_t     victim_way,
  input  wire cache_pkg::tag_t     victim_tag,
  input  wire logic                victim_dirty,
  output logic                     upd_en,
  output cache_pkg::way_t          upd_way,
  output logic                     fill_en,
  output logic                     set_dirty,
  output cache_pkg::ds_addr_t      rd_addr,
  input  wire cache_pkg::word_t    rd_data,
  output logic                     wr_en,
  output cache_pkg::ds_addr_t      wr_addr,
  output cache_pkg::be_t           wr_be,
  output cache_pkg::word_t         wr_data
);

  cache_pkg::cache_addr_u req_addr;
  cache_pkg::cache_addr_u line_addr;
  cache_pkg::ctrl_state_t state_q, state_d;
  cache_pkg::way_t        way_q;
  cache_pkg::word_off_t   beat_q;
  logic                   rd_issued_q;
  logic                   wb_beat;
  logic                   fill_beat;
  logic                   last_beat;

  // the CPU holds its request until completion, so it is decoded directly.
  assign req_addr.flat = cpu_req.address;
  assign index         = req_addr.fields.index;
  assign lookup_tag    = req_addr.fields.tag;

  assign wb_beat   = state_q == cache_pkg::st_writeback && !mem_waitrequest;
  assign fill_beat = state_q == cache_pkg::st_refill && mem_rd_valid;
  assign last_beat = beat_q == '1;

  // ------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      cache_pkg::st_idle:      if (cpu_req.rd || cpu_req.wr) state_d = cache_pkg::st_lookup;
      cache_pkg::st_lookup: begin
        if (hit)               state_d = cache_pkg::st_respond;
        else if (victim_dirty) state_d = cache_pkg::st_writeback;
        else                   state_d = cache_pkg::st_refill;
      end
      cache_pkg::st_writeback: if (wb_beat && last_beat) state_d = cache_pkg::st_refill;
      cache_pkg::st_refill:    if (fill_beat && last_beat) state_d = cache_pkg::st_lookup;
      cache_pkg::st_respond:   state_d = cache_pkg::st_idle;
      default:                 state_d = cache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state_q     <= cache_pkg::st_idle;
      beat_q      <= '0;
      rd_issued_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wb_beat || fill_beat) beat_q <= beat_q + 1'b1; // wraps to zero after each burst.
      if (state_q != cache_pkg::st_refill) begin
        rd_issued_q <= 1'b0;
      end else if (mem_req.rd && !mem_waitrequest) begin
        rd_issued_q <= 1'b1;
      end
    end
  end

  // hit way on a hit, line to replace on a miss.
  always_ff @(posedge clock) begin
    if (state_q == cache_pkg::st_lookup) way_q <= hit ? hit_way : victim_way;
  end

  // ------------------------------------------------------------
  // data store access
  // ------------------------------------------------------------

  // a dirty miss reads victim word 0 during lookup, then one word ahead per accepted beat.
  always_comb begin
    rd_addr.set  = index;
    rd_addr.way  = way_q;
    rd_addr.word = beat_q;
    if (state_q == cache_pkg::st_lookup) begin
      rd_addr.way  = hit ? hit_way : victim_way;
      rd_addr.word = hit ? req_addr.fields.word_off : beat_q;
    end else if (wb_beat) begin
      rd_addr.word = beat_q + 1'b1;
    end
  end

  assign wr_en        = fill_beat || (state_q == cache_pkg::st_respond && cpu_req.wr);
  assign wr_addr.set  = index;
  assign wr_addr.way  = way_q;
  assign wr_addr.word = fill_beat ? beat_q : req_addr.fields.word_off;
  assign wr_be        = fill_beat ? '1 : cpu_req.be;
  assign wr_data      = fill_beat ? mem_rd_data : cpu_req.wdata;

  // ------------------------------------------------------------
  // tag store, CPU and memory ports
  // ------------------------------------------------------------

  assign upd_en    = state_q == cache_pkg::st_respond;
  assign upd_way   = way_q;
  assign fill_en   = fill_beat && last_beat;
  assign set_dirty = state_q == cache_pkg::st_respond && cpu_req.wr;

  assign cpu_waitrequest = state_q != cache_pkg::st_respond;
  assign cpu_rd_data     = rd_data;

  always_comb begin
    line_addr.fields.tag      = req_addr.fields.tag;
    line_addr.fields.index    = index;
    line_addr.fields.word_off = '0;
    line_addr.fields.byte_off = '0;
    if (state_q == cache_pkg::st_writeback) line_addr.fields.tag = victim_tag;
  end

  always_comb begin
    mem_req           = '0;
    mem_req.address   = line_addr.flat;
    mem_req.burst_len = 2'(`CACHE_LINE_WORDS - 1);
    mem_req.rd        = state_q == cache_pkg::st_refill && !rd_issued_q;
    mem_req.wr        = state_q == cache_pkg::st_writeback;
    mem_req.wdata     = rd_data;
  end

endmodule

`default_nettype wire

//--- cache_data_store.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module cache_data_store (
  input  wire logic                clock,
  input  wire cache_pkg::ds_addr_t rd_addr,
  output cache_pkg::word_t         rd_data,
  input  wire logic                wr_en,
  input  wire cache_pkg::ds_addr_t wr_addr,
  input  wire cache_pkg::be_t      wr_be,
  input  wire cache_pkg::word_t    wr_data
);

  localparam int unsigned DEPTH = `CACHE_SETS * `CACHE_WAYS * `CACHE_LINE_WORDS;

  // ------------------------------------------------------------
  // word array, one entry per word of every way of every set
  // ------------------------------------------------------------

  cache_pkg::word_t mem_q [DEPTH];

  // a read in the same cycle as a write to that word returns the old value.
  always_ff @(posedge clock) begin
    rd_data <= mem_q[rd_addr];
  end

  // refill beats come in with every byte enabled.
  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int b = 0; b < `CACHE_DATA_W / 8; b++) begin
        if (wr_be[b]) mem_q[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- cache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module cache_tag_store (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire cache_pkg::index_t index,
  input  wire cache_pkg::tag_t   lookup_tag,
  output logic                   hit,
  output cache_pkg::way_t        hit_way,
  output cache_pkg::way_t        victim_way,
  output cache_pkg::tag_t        victim_tag,
  output logic                   victim_dirty,
  input  wire logic              upd_en,
  input  wire cache_pkg::way_t   upd_way,
  input  wire logic              fill_en,
  input  wire logic              set_dirty
);

  cache_pkg::tag_t   tag_q   [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::way_t   age_q   [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
  cache_pkg::index_t index_q;

  // ------------------------------------------------------------
  // lookup on the registered index
  // ------------------------------------------------------------

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (valid_q[index_q][w] && tag_q[index_q][w] == lookup_tag) begin
        hit     = 1'b1;
        hit_way = cache_pkg::way_t'(w);
      end
    end
  end

  // an invalid way beats the oldest one, and the lowest invalid way wins.
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (age_q[index_q][w] == '1) victim_way = cache_pkg::way_t'(w);
    end
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[index_q][w]) victim_way = cache_pkg::way_t'(w);
    end
  end

  assign victim_tag   = tag_q[index_q][victim_way];
  assign victim_dirty = valid_q[index_q][victim_way] && dirty_q[index_q][victim_way];

  // ------------------------------------------------------------
  // updates
  // ------------------------------------------------------------

  always_ff @(posedge clock) begin
    index_q <= index;
    if (fill_en) tag_q[index_q][upd_way] <= lookup_tag;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          age_q[s][w] <= cache_pkg::way_t'(w); // ages stay a permutation of the ways.
        end
      end
    end else begin
      if (fill_en) begin
        valid_q[index_q][upd_way] <= 1'b1;
        dirty_q[index_q][upd_way] <= 1'b0;
      end
      if (set_dirty) dirty_q[index_q][upd_way] <= 1'b1;
      if (upd_en) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          if (cache_pkg::way_t'(w) == upd_way) begin
            age_q[index_q][w] <= '0;
          end else if (age_q[index_q][w] < age_q[index_q][upd_way]) begin
            age_q[index_q][w] <= age_q[index_q][w] + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

  typedef logic [`CACHE_DATA_W-1:0]              word_t;
  typedef logic [`CACHE_DATA_W/8-1:0]            be_t;
  typedef logic [$clog2(`CACHE_SETS)-1:0]        index_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0]        way_t;
  typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0]  word_off_t;
  typedef logic [$clog2(`CACHE_DATA_W/8)-1:0]    byte_off_t;
  typedef logic [`CACHE_ADDR_W-$bits(index_t)-$bits(word_off_t)-$bits(byte_off_t)-1:0] tag_t;

  typedef struct packed {
    tag_t      tag;
    index_t    index;
    word_off_t word_off;
    byte_off_t byte_off;
  } addr_fields_t;

  // flat byte address towards memory, split fields towards the stores.
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] flat;
    addr_fields_t             fields;
  } cache_addr_u;

  typedef struct packed {
    index_t    set;
    way_t      way;
    word_off_t word;
  } ds_addr_t;

  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] address;
    logic                     rd;
    logic                     wr;
    be_t                      be;
    word_t                    wdata;
  } cpu_req_t;

  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] address;
    logic [1:0]               burst_len; // beats minus one.
    logic                     rd;
    logic                     wr;
    word_t                    wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_writeback,
    st_refill,
    st_respond
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// ------------------------------------------------------------
// cache geometry
// ------------------------------------------------------------

// byte address width on both the CPU and memory ports.
`define CACHE_ADDR_W 32

// width of one CPU word and of one memory beat.
`define CACHE_DATA_W 32

// a line is one 4-beat burst.
`define CACHE_LINE_WORDS 4

`define CACHE_SETS 16

// age counters are sized from this, so keep it a power of two.
`define CACHE_WAYS 4

`endif
